// ==== Makefile ====
# Verilator lint and simulation of the rv_core pipeline

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_core.f --top-module rv_core

sim:
	verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb \
		-Mdir obj_dir -o rv_core_sim
	./obj_dir/rv_core_sim | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/clock_gen.sv ====
// Testbench clock source with a period of 10 time units
module clock_gen (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

endmodule

// ==== bench/rv_core_tb.sv ====
// Testbench for the pipeline: directed and random programs checked against a register model
`include "rv_core_defines.svh"

module rv_core_tb;

    localparam logic [4:0] report_first = `RV_REPORT_FIRST;
    localparam logic [4:0] report_last  = `RV_REPORT_LAST;
    localparam logic [4:0] report_extra = `RV_REPORT_EXTRA;
    // Whole program runs in roughly 700 cycles
    localparam int unsigned cycle_limit = 3000;

    logic               clock;
    logic               reset;
    logic [31:0]        instruction;
    logic               instruction_valid;
    logic               result_valid;
    logic [4:0]         result_reg;
    logic [31:0]        result_data;
    rv_core_pkg::word_t model [`RV_NUM_REGS];
    logic [4:0]         pending_reg [$];
    rv_core_pkg::word_t pending_data [$];
    int unsigned        pending_due [$];
    string              pending_name [$];
    logic               exp_valid;
    logic [4:0]         exp_reg;
    rv_core_pkg::word_t exp_data;
    string              exp_name;
    string              test_name;
    int unsigned        cycle;
    logic [31:0]        word;
    logic [4:0]         prev;
    logic [4:0]         dest;

    clock_gen i_clock_gen (.clock(clock));

    rv_core i_rv_core (
        .clock             (clock),
        .reset             (reset),
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .result_valid      (result_valid),
        .result_reg        (result_reg),
        .result_data       (result_data)
    );

    ////////////////////
    // Encoders
    ////////////////////

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, rv_core_pkg::OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd);
        return {imm, rs1, funct3, rd, rv_core_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_core_pkg::LUI};
    endfunction

    // Reported registers only, or also x5..x8 when wide
    function automatic logic [4:0] pick_reg(input logic wide);
        int unsigned n;
        n = $urandom_range(0, wide ? 12 : 8);
        return (n < 8) ? 5'(18 + n) : (n == 8) ? report_extra : 5'(n - 4);
    endfunction

    function automatic logic [31:0] random_op_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                   input logic [4:0] rs2);
        logic [2:0] funct3;
        funct3 = 3'($urandom_range(0, 7));
        // Only ADD/SUB and SRL/SRA take funct7 bit 5
        return r_type((funct3 == 3'd0 || funct3 == 3'd5) ? {1'b0, 1'($urandom), 5'b0} : 7'd0,
                      rs2, rs1, funct3, rd);
    endfunction

    function automatic logic [31:0] random_alu_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                    input logic [4:0] rs2);
        logic [2:0]  funct3;
        logic [11:0] imm;
        logic [31:0] result;
        funct3 = 3'($urandom_range(0, 7));
        imm    = 12'($urandom);
        // Shift immediates: shamt plus the SRAI bit
        if (funct3 == 3'd1 || funct3 == 3'd5) begin
            imm[11:5] = {1'b0, funct3[2] & imm[10], 5'b0};
        end
        case ($urandom_range(0, 9))
            0:          result = lui_word(20'($urandom), rd);
            1, 2, 3, 4: result = i_type(imm, rs1, funct3, rd);
            default:    result = random_op_word(rd, rs1, rs2);
        endcase
        return result;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    task automatic model_step(input logic [31:0] w);
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t value;
        logic               is_op;
        logic               writes;
        is_op  = (w[6:0] == rv_core_pkg::OP);
        writes = is_op || (w[6:0] == rv_core_pkg::OP_IMM);
        a      = model[w[19:15]];
        b      = is_op ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
        case (w[14:12])
            3'd0:    value = (is_op && w[30]) ? a - b : a + b;
            3'd1:    value = a << b[4:0];
            3'd2:    value = {31'b0, $signed(a) < $signed(b)};
            3'd3:    value = {31'b0, a < b};
            3'd4:    value = a ^ b;
            3'd5: begin
                if (w[30]) begin
                    value = $signed(a) >>> b[4:0];
                end else begin
                    value = a >> b[4:0];
                end
            end
            3'd6:    value = a | b;
            default: value = a & b;
        endcase
        if (w[6:0] == rv_core_pkg::LUI) begin
            value  = {w[31:12], 12'b0};
            writes = 1'b1;
        end
        if (writes && w[11:7] != 5'd0) begin
            model[w[11:7]] = value;
            if (w[11:7] == report_extra ||
                (w[11:7] >= report_first && w[11:7] <= report_last)) begin
                // Sampled on the next edge, reported two edges after that
                pending_reg.push_back(w[11:7]);
                pending_data.push_back(value);
                pending_due.push_back(cycle + 3);
                pending_name.push_back(test_name);
            end
        end
    endtask

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic issue_word(input logic [31:0] w);
        @(negedge clock);
        instruction       = w;
        instruction_valid = 1'b1;
        model_step(w);
    endtask

    // Bubbles carry random junk on the instruction bus
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            instruction       = $urandom();
            instruction_valid = 1'b0;
        end
    endtask

    task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
        issue_word(lui_word(value[31:12] + 20'(value[11]), rd));
        issue_word(i_type(value[11:0], rd, 3'd0, rd));
    endtask

    task automatic fail_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at cycle %0d", cycle);
    endtask

    ////////////////////
    // Checking
    ////////////////////

    always @(posedge clock) begin
        if (reset) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the program", cycle);
            fail_run();
        end
    end

    // Head of the queue becomes the expectation in the cycle it falls due
    always @(negedge clock) begin
        if (!reset && pending_due.size() != 0 && pending_due[0] == cycle) begin
            exp_valid <= 1'b1;
            exp_reg   <= pending_reg.pop_front();
            exp_data  <= pending_data.pop_front();
            exp_name  <= pending_name.pop_front();
            void'(pending_due.pop_front());
        end else begin
            exp_valid <= 1'b0;
        end
    end

    assert property (@(posedge clock) disable iff (reset) exp_valid |-> result_valid)
        else begin
            $display("Result report missing in test %s at cycle %0d", exp_name, cycle);
            fail_run();
        end

    assert property (@(posedge clock) disable iff (reset) result_valid |-> exp_valid)
        else begin
            $display("Unexpected result report for x%0d during test %s at cycle %0d",
                     $sampled(result_reg), test_name, cycle);
            fail_run();
        end

    assert property (@(posedge clock) disable iff (reset)
        (result_valid && exp_valid) |-> (result_reg == exp_reg))
        else begin
            $display("ERR %s result_reg expected %0d actual %0d",
                     exp_name, exp_reg, $sampled(result_reg));
            fail_run();
        end

    assert property (@(posedge clock) disable iff (reset)
        (result_valid && exp_valid) |-> (result_data == exp_data))
        else begin
            $display("ERR %s result_data expected %h actual %h",
                     exp_name, exp_data, $sampled(result_data));
            fail_run();
        end

    ////////////////////
    // Program
    ////////////////////

    initial begin
        void'($urandom(7));
        reset             = 1'b1;
        instruction       = '0;
        instruction_valid = 1'b0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;

        // Unreported writes first, then the first reports
        test_name = "reset_quiet";
        issue_word(i_type(12'd17, 5'd0, 3'd0, 5'd5));
        issue_word(i_type(12'd3, 5'd5, 3'd6, 5'd6));
        issue_word(r_type(7'd0, 5'd6, 5'd5, 3'd4, 5'd7));
        idle(3);
        issue_word(lui_word(20'habcde, 5'd18));
        issue_word(i_type(12'hf9c, 5'd18, 3'd0, 5'd9));

        test_name = "every_operation";
        repeat (12) begin
            load_value(5'd20, $urandom());
            load_value(5'd21, $urandom());
            for (int f = 0; f < 8; f++) begin
                issue_word(r_type(7'd0, 5'd21, 5'd20, 3'(f), 5'd22));
                issue_word(i_type((f == 1 || f == 5) ? {7'd0, 5'($urandom)} : 12'($urandom),
                                  5'd20, 3'(f), 5'd23));
                if (f == 0 || f == 5) begin
                    issue_word(r_type(7'b0100000, 5'd21, 5'd20, 3'(f), 5'd24));
                end
                if (f == 5) begin
                    issue_word(i_type({7'b0100000, 5'($urandom)}, 5'd20, 3'd5, 5'd25));
                end
            end
        end

        // Each instruction reads the previous rd
        test_name = "dependent_chain";
        prev = 5'd18;
        for (int n = 0; n < 60; n++) begin
            dest = pick_reg(1'b0);
            case (n % 4)
                0:       word = random_op_word(dest, prev, prev);
                1:       word = random_op_word(dest, prev, 5'd9);
                2:       word = random_op_word(dest, 5'd19, prev);
                default: word = i_type(12'($urandom), prev, 3'd0, dest);
            endcase
            issue_word(word);
            prev = dest;
        end

        test_name = "distance_and_bubbles";
        repeat (120) begin
            issue_word(random_alu_word(pick_reg(1'b1), pick_reg(1'b1), pick_reg(1'b1)));
            idle($urandom_range(0, 3));
        end

        test_name = "zero_and_junk";
        issue_word(i_type(12'h123, 5'd0, 3'd0, 5'd0));
        issue_word(lui_word(20'hfffff, 5'd0));
        issue_word(r_type(7'd0, 5'd0, 5'd0, 3'd0, 5'd18));
        issue_word(i_type(12'd77, 5'd0, 3'd6, 5'd19));
        // Load, branch and JAL encodings aimed at x19
        word      = i_type(12'd5, 5'd19, 3'd0, 5'd19);
        word[6:0] = 7'b0000011;
        issue_word(word);
        word[6:0] = 7'b1100011;
        issue_word(word);
        word[6:0] = 7'b1101111;
        issue_word(word);
        idle(5);
        issue_word(r_type(7'd0, 5'd0, 5'd19, 3'd0, 5'd20));
        idle(4);

        if (pending_due.size() != 0) begin
            $display("Run ended with %0d result reports never seen", pending_due.size());
            fail_run();
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== rv_core.f ====
+incdir+source
source/rv_core_pkg.sv
source/issue_if.sv
source/decode_stage.sv
source/operand_forward.sv
source/execute_stage.sv
source/rv_core.sv
bench/clock_gen.sv
bench/rv_core_tb.sv

// ==== source/decode_stage.sv ====
// Decode stage: register file with write-through read, decoder, decode/execute register
`include "rv_core_defines.svh"

module decode_stage (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [31:0]            instruction,
    input  logic                   instruction_valid,
    input  logic                   wb_write,
    input  rv_core_pkg::reg_addr_t wb_reg,
    input  rv_core_pkg::word_t     wb_data,
    issue_if.decode                issue
);

    rv_core_pkg::word_t     regs [`RV_NUM_REGS];
    rv_core_pkg::reg_addr_t rs [2];
    rv_core_pkg::word_t     rs_data [2];
    rv_core_pkg::opcode_e   opcode;
    logic [2:0]             funct3;
    logic                   alt;
    rv_core_pkg::alu_op_e   alu_op;
    rv_core_pkg::word_t     imm;
    logic                   use_imm;
    logic                   reg_write;

    ////////////////////
    // Register file
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write) begin
            regs[wb_reg] <= wb_data;
        end
    end

    assign rs[0] = instruction[19:15];
    assign rs[1] = instruction[24:20];

    // Same-cycle writeback wins, covers the distance-two dependency
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (rs[i] == '0) begin
                rs_data[i] = '0;
            end else if (wb_write && (wb_reg == rs[i])) begin
                rs_data[i] = wb_data;
            end else begin
                rs_data[i] = regs[rs[i]];
            end
        end
    end

    ////////////////////
    // Decoder
    ////////////////////

    assign opcode = rv_core_pkg::opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    // funct7 bit 5 picks SUB and SRA
    assign alt    = instruction[30];

    always_comb begin
        alu_op    = rv_core_pkg::ADD;
        imm       = {{20{instruction[31]}}, instruction[31:20]};
        use_imm   = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            rv_core_pkg::OP, rv_core_pkg::OP_IMM: begin
                use_imm   = (opcode == rv_core_pkg::OP_IMM);
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = (alt && !use_imm) ? rv_core_pkg::SUB : rv_core_pkg::ADD;
                    3'b001:  alu_op = rv_core_pkg::SLL;
                    3'b010:  alu_op = rv_core_pkg::SLT;
                    3'b011:  alu_op = rv_core_pkg::SLTU;
                    3'b100:  alu_op = rv_core_pkg::XOR;
                    3'b101:  alu_op = alt ? rv_core_pkg::SRA : rv_core_pkg::SRL;
                    3'b110:  alu_op = rv_core_pkg::OR;
                    default: alu_op = rv_core_pkg::AND;
                endcase
            end
            rv_core_pkg::LUI: begin
                alu_op    = rv_core_pkg::PASS_B;
                imm       = {instruction[31:12], 12'b0};
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            // Anything else flows on and writes nothing
            default: begin
            end
        endcase
    end

    ////////////////////
    // Decode/execute register
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid     <= 1'b0;
            issue.reg_write <= 1'b0;
        end else begin
            issue.valid     <= instruction_valid;
            issue.reg_write <= reg_write;
        end
    end

    always_ff @(posedge clock) begin
        issue.alu_op   <= alu_op;
        issue.rd       <= instruction[11:7];
        issue.src_reg  <= rs;
        issue.src_data <= rs_data;
        issue.imm      <= imm;
        issue.use_imm  <= use_imm;
    end

    // Writeback bundle comes from execute and must already exclude x0
    assert property (@(posedge clock) disable iff (reset) wb_write |-> (wb_reg != '0));

endmodule

// ==== source/execute_stage.sv ====
// Execute stage: ALU, execute/writeback register and result reporting register
`include "rv_core_defines.svh"

module execute_stage (
    input  logic                   clock,
    input  logic                   reset,
    issue_if.execute               issue,
    input  rv_core_pkg::word_t     operand_a,
    input  rv_core_pkg::word_t     operand_b,
    output logic                   wb_write,
    output rv_core_pkg::reg_addr_t wb_reg,
    output rv_core_pkg::word_t     wb_data,
    output logic                   result_valid,
    output rv_core_pkg::reg_addr_t result_reg,
    output rv_core_pkg::word_t     result_data
);

    localparam rv_core_pkg::reg_addr_t report_first = `RV_REPORT_FIRST;
    localparam rv_core_pkg::reg_addr_t report_last  = `RV_REPORT_LAST;
    localparam rv_core_pkg::reg_addr_t report_extra = `RV_REPORT_EXTRA;

    rv_core_pkg::word_t src_b;
    rv_core_pkg::word_t alu_result;
    logic [4:0]         shamt;
    logic               reportable;

    ////////////////////
    // ALU
    ////////////////////

    assign src_b = issue.use_imm ? issue.imm : operand_b;
    assign shamt = src_b[4:0];

    always_comb begin
        case (issue.alu_op)
            rv_core_pkg::ADD:  alu_result = operand_a + src_b;
            rv_core_pkg::SUB:  alu_result = operand_a - src_b;
            rv_core_pkg::AND:  alu_result = operand_a & src_b;
            rv_core_pkg::OR:   alu_result = operand_a | src_b;
            rv_core_pkg::XOR:  alu_result = operand_a ^ src_b;
            rv_core_pkg::SLL:  alu_result = operand_a << shamt;
            rv_core_pkg::SRL:  alu_result = operand_a >> shamt;
            rv_core_pkg::SRA:  alu_result = $signed(operand_a) >>> shamt;
            rv_core_pkg::SLT: begin
                alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(operand_a) < $signed(src_b)};
            end
            rv_core_pkg::SLTU: begin
                alu_result = {{(`RV_XLEN-1){1'b0}}, operand_a < src_b};
            end
            // PASS_B, LUI immediate
            default:           alu_result = src_b;
        endcase
    end

    ////////////////////
    // Execute/writeback register
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_write <= 1'b0;
        end else begin
            wb_write <= issue.valid && issue.reg_write && (issue.rd != '0);
        end
    end

    always_ff @(posedge clock) begin
        wb_reg  <= issue.rd;
        wb_data <= alu_result;
    end

    ////////////////////
    // Result reporting
    ////////////////////

    // s1 plus s2..s9
    assign reportable = wb_write &&
        ((wb_reg == report_extra) || ((wb_reg >= report_first) && (wb_reg <= report_last)));

    // Loaded on the same edge as the register file write
    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= reportable;
        end
    end

    always_ff @(posedge clock) begin
        if (reportable) begin
            result_reg  <= wb_reg;
            result_data <= wb_data;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        result_valid |-> ((result_reg == report_extra) ||
                          ((result_reg >= report_first) && (result_reg <= report_last))));

endmodule

// ==== source/issue_if.sv ====
// Decoded instruction bundle from the decode/execute register to forwarding and execute
interface issue_if;

    logic                   valid;
    rv_core_pkg::alu_op_e   alu_op;
    rv_core_pkg::reg_addr_t rd;
    logic                   reg_write;
    rv_core_pkg::reg_addr_t src_reg [2];
    rv_core_pkg::word_t     src_data [2];
    rv_core_pkg::word_t     imm;
    logic                   use_imm;

    // Driven from the decode/execute register
    modport decode (
        output valid, alu_op, rd, reg_write, src_reg, src_data, imm, use_imm
    );

    modport execute (
        input valid, alu_op, rd, reg_write, imm, use_imm
    );

    // Source operands only, one entry per forwarding unit
    modport forward (
        input src_reg, src_data
    );

endinterface

// ==== source/operand_forward.sv ====
// Operand forwarding from the execute/writeback register to one ALU source
module operand_forward (
    input  rv_core_pkg::reg_addr_t src_reg,
    input  rv_core_pkg::word_t     src_data,
    input  logic                   wb_write,
    input  rv_core_pkg::reg_addr_t wb_reg,
    input  rv_core_pkg::word_t     wb_data,
    output rv_core_pkg::word_t     operand
);

    logic use_wb;

    // wb_write is never set for x0, so no zero check here
    assign use_wb  = wb_write && (wb_reg == src_reg);
    assign operand = use_wb ? wb_data : src_data;

    // x0 reads must always come from the register file path
    always_comb begin
        assert final (!(use_wb && (src_reg == '0)));
    end

endmodule

// ==== source/rv_core.sv ====
// Three-stage integer pipeline top: decode, operand forwarding and execute
`include "rv_core_defines.svh"

module rv_core (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [31:0]                  instruction,
    input  logic                         instruction_valid,
    output logic                         result_valid,
    output logic [`RV_REG_ADDR_BITS-1:0] result_reg,
    output logic [`RV_XLEN-1:0]          result_data
);

    issue_if issue ();

    // Writeback bundle from the execute/writeback register
    logic                   wb_write;
    rv_core_pkg::reg_addr_t wb_reg;
    rv_core_pkg::word_t     wb_data;

    rv_core_pkg::word_t     operand [2];

    decode_stage i_decode_stage (
        .clock             (clock),
        .reset             (reset),
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .wb_write          (wb_write),
        .wb_reg            (wb_reg),
        .wb_data           (wb_data),
        .issue             (issue.decode)
    );

    // One forwarding unit per ALU source
    for (genvar i = 0; i < 2; i++) begin : g_forward
        operand_forward i_operand_forward (
            .src_reg  (issue.src_reg[i]),
            .src_data (issue.src_data[i]),
            .wb_write (wb_write),
            .wb_reg   (wb_reg),
            .wb_data  (wb_data),
            .operand  (operand[i])
        );
    end

    execute_stage i_execute_stage (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue.execute),
        .operand_a    (operand[0]),
        .operand_b    (operand[1]),
        .wb_write     (wb_write),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

endmodule

// ==== source/rv_core_defines.svh ====
// Pipeline width, register file size and reported register range macros
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

////////////////////
// Datapath
////////////////////

// Data word width
`define RV_XLEN 32

// Register file geometry
`define RV_REG_ADDR_BITS 5
`define RV_NUM_REGS 32

////////////////////
// Result reporting
////////////////////

// Saved registers s2..s9 and s1 carry final results
`define RV_REPORT_FIRST 18
`define RV_REPORT_LAST 25
`define RV_REPORT_EXTRA 9

`endif

// ==== source/rv_core_pkg.sv ====
// Shared pipeline types: data words, register numbers, opcodes and ALU operations
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_ADDR_BITS-1:0] reg_addr_t;

    // Major opcodes in instruction bits 6:0
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcode_e;

    // ALU operations selected in decode
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        // B operand straight through, used by LUI
        PASS_B = 4'd10
    } alu_op_e;

endpackage
